// ==== src/cdec_settings.svh ====
`ifndef CDEC_SETTINGS_SVH
`define CDEC_SETTINGS_SVH

// extension switches
// 1 means the extension is built in

// Zcb code-size reduction subset
`define CDEC_ZC_EXT 1'b1

// integer multiply
`define CDEC_M_EXT 1'b1

// bit manipulation (sext/zext forms)
`define CDEC_B_EXT 1'b1

// word widths
// full instruction word
`define CDEC_ILEN 32
// compressed halfword
`define CDEC_CLEN 16

`endif

// ==== src/cdec_pkg.sv ====
`include "cdec_settings.svh"

`default_nettype none

package cdec_pkg;

  ////////////////////////////////////////
  // word types
  ////////////////////////////////////////

  // full length instruction word
  typedef logic [`CDEC_ILEN-1:0] instr_t;
  // compressed halfword
  typedef logic [`CDEC_CLEN-1:0] cinstr_t;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // major opcodes of the expanded word
  typedef enum logic [6:0] {
    OPCODE_OPIMM  = 7'h13,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_LOAD   = 7'h03,
    OPCODE_STORE  = 7'h23,
    OPCODE_JAL    = 7'h6f,
    OPCODE_JALR   = 7'h67,
    OPCODE_BRANCH = 7'h63,
    OPCODE_SYSTEM = 7'h73
  } opcode_e;

  // low two bits of a fetched word
  // 11 marks a 32-bit instruction
  typedef enum logic [1:0] {
    Q0   = 2'b00,
    Q1   = 2'b01,
    Q2   = 2'b10,
    FULL = 2'b11
  } quadrant_e;

  // register numbers
  localparam logic [4:0] REG_RA = 5'd1;
  localparam logic [4:0] REG_SP = 5'd2;
  // upper bits of a 3-bit register field, selects x8..x15
  localparam logic [1:0] CREG_PREFIX = 2'b01;

  // ebreak has funct12 of 1 and all other fields zero
  localparam instr_t EBREAK_WORD = {12'h001, 5'd0, 3'b000, 5'd0, OPCODE_SYSTEM};

endpackage

`default_nettype wire

// ==== src/cdec_quadrant0.sv ====
`include "cdec_settings.svh"

`timescale 1ns/1ps
`default_nettype none

module cdec_quadrant0 #(
  parameter bit ZC_EXT = `CDEC_ZC_EXT
) (
  input  cdec_pkg::cinstr_t cinstr_i,
  output cdec_pkg::instr_t  instr_o,
  output logic              illegal_o
);

  import cdec_pkg::*;

  // short local name for the halfword
  logic [`CDEC_CLEN-1:0] c;
  // expanded register numbers of the 3-bit fields
  logic [4:0] rs1c;
  logic [4:0] rdc;
  // c.lw expansion, also the word for illegal slots
  instr_t lw_word;

  assign c    = cinstr_i;
  assign rs1c = {CREG_PREFIX, c[9:7]};
  assign rdc  = {CREG_PREFIX, c[4:2]};

  // offset bits 6 | 5:3 | 2 come from c[5] c[12:10] c[6]
  assign lw_word = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1c, 3'b010, rdc, OPCODE_LOAD};

  always_comb begin
    instr_o   = lw_word;
    illegal_o = 1'b0;

    case (c[15:13])
      3'b000: begin
        // c.addi4spn becomes addi rd' x2 nzuimm
        instr_o = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00, REG_SP, 3'b000, rdc,
                   OPCODE_OPIMM};
        // zero immediate is reserved
        if (c[12:5] == 8'b0) begin
          illegal_o = 1'b1;
        end
      end

      3'b010: begin
        // c.lw
        instr_o = lw_word;
      end

      3'b110: begin
        // c.sw becomes sw rs2' offset(rs1')
        instr_o = {5'b0, c[5], c[12], rdc, rs1c, 3'b010, c[11:10], c[6], 2'b00, OPCODE_STORE};
      end

      3'b100: begin
        if (ZC_EXT) begin
          case (c[12:10])
            // c.lbu with a two bit offset
            3'b000: instr_o = {10'b0, c[5], c[6], rs1c, 3'b100, rdc, OPCODE_LOAD};
            // c.lh and c.lhu share a slot
            // bit 6 set selects sign extension
            3'b001: instr_o = {10'b0, c[5], 1'b0, rs1c, ~c[6], 2'b01, rdc, OPCODE_LOAD};
            // c.sb
            3'b010: instr_o = {7'b0, rdc, rs1c, 3'b000, 3'b000, c[5], c[6], OPCODE_STORE};
            3'b011: begin
              // c.sh
              instr_o = {7'b0, rdc, rs1c, 3'b001, 3'b000, c[5], 1'b0, OPCODE_STORE};
              // halfword store must be aligned
              if (c[6]) begin
                illegal_o = 1'b1;
              end
            end
            default: begin
              // remaining Zcb load/store slots unused
              illegal_o = 1'b1;
            end
          endcase
        end else begin
          illegal_o = 1'b1;
        end
      end

      default: begin
        // float load/store and reserved slots
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/cdec_quadrant1.sv ====
`include "cdec_settings.svh"

`timescale 1ns/1ps
`default_nettype none

module cdec_quadrant1 #(
  parameter bit ZC_EXT = `CDEC_ZC_EXT,
  parameter bit M_EXT  = `CDEC_M_EXT,
  parameter bit B_EXT  = `CDEC_B_EXT
) (
  input  cdec_pkg::cinstr_t cinstr_i,
  output cdec_pkg::instr_t  instr_o,
  output logic              illegal_o
);

  import cdec_pkg::*;

  logic [`CDEC_CLEN-1:0] c;
  // rd'/rs1' and rs2' as full register numbers
  logic [4:0] rsdc;
  logic [4:0] rs2c;
  // c.and expansion, reused for illegal register-register slots
  instr_t and_word;

  assign c    = cinstr_i;
  assign rsdc = {CREG_PREFIX, c[9:7]};
  assign rs2c = {CREG_PREFIX, c[4:2]};

  assign and_word = {7'b0, rs2c, rsdc, 3'b111, rsdc, OPCODE_OP};

  always_comb begin
    instr_o   = and_word;
    illegal_o = 1'b0;

    case (c[15:13])
      ////////////////////////////////////////
      // immediates and jumps
      ////////////////////////////////////////
      3'b000: begin
        // c.addi and c.nop
        instr_o = {{7{c[12]}}, c[6:2], c[11:7], 3'b000, c[11:7], OPCODE_OPIMM};
      end

      3'b001, 3'b101: begin
        // c.jal links to ra
        // c.j links to x0
        instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], {9{c[12]}},
                   c[15] ? 5'd0 : REG_RA, OPCODE_JAL};
      end

      3'b010: begin
        // c.li adds to x0
        // rd of x0 is a hint and expands the same way
        instr_o = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, c[11:7], OPCODE_OPIMM};
      end

      3'b011: begin
        if (c[11:7] == REG_SP) begin
          // c.addi16sp scales the immediate by 16
          instr_o = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0, REG_SP, 3'b000, REG_SP,
                     OPCODE_OPIMM};
        end else begin
          // c.lui
          instr_o = {{15{c[12]}}, c[6:2], c[11:7], OPCODE_LUI};
        end
        // zero immediate is reserved for both forms
        if ({c[12], c[6:2]} == 6'b0) begin
          illegal_o = 1'b1;
        end
      end

      ////////////////////////////////////////
      // arithmetic on x8..x15
      ////////////////////////////////////////
      3'b100: begin
        case (c[11:10])
          2'b00, 2'b01: begin
            // c.srli and c.srai
            // bit 10 picks the arithmetic form
            instr_o = {1'b0, c[10], 5'b0, c[6:2], rsdc, 3'b101, rsdc, OPCODE_OPIMM};
            // shamt[5] is not valid on RV32
            if (c[12]) begin
              illegal_o = 1'b1;
            end
          end

          2'b10: begin
            // c.andi
            instr_o = {{7{c[12]}}, c[6:2], rsdc, 3'b111, rsdc, OPCODE_OPIMM};
          end

          default: begin
            case ({c[12], c[6:5]})
              3'b000: instr_o = {7'b0100000, rs2c, rsdc, 3'b000, rsdc, OPCODE_OP};
              3'b001: instr_o = {7'b0, rs2c, rsdc, 3'b100, rsdc, OPCODE_OP};
              3'b010: instr_o = {7'b0, rs2c, rsdc, 3'b110, rsdc, OPCODE_OP};
              3'b011: instr_o = and_word;
              3'b110: begin
                // c.mul
                if (ZC_EXT && M_EXT) begin
                  instr_o = {7'b0000001, rs2c, rsdc, 3'b000, rsdc, OPCODE_OP};
                end else begin
                  illegal_o = 1'b1;
                end
              end
              3'b111: begin
                // Zcb unary group, selected by the rs2' field
                if (ZC_EXT) begin
                  case (c[4:2])
                    3'b000: begin
                      // c.zext.b is andi with 0xff
                      instr_o = {12'h0ff, rsdc, 3'b111, rsdc, OPCODE_OPIMM};
                    end
                    3'b001: begin
                      // c.sext.b
                      instr_o = {12'h604, rsdc, 3'b001, rsdc, OPCODE_OPIMM};
                      illegal_o = ~B_EXT;
                    end
                    3'b010: begin
                      // c.zext.h uses the zext.h encoding of OP
                      instr_o = {12'h080, rsdc, 3'b100, rsdc, OPCODE_OP};
                      illegal_o = ~B_EXT;
                    end
                    3'b011: begin
                      // c.sext.h
                      instr_o = {12'h605, rsdc, 3'b001, rsdc, OPCODE_OPIMM};
                      illegal_o = ~B_EXT;
                    end
                    3'b101: begin
                      // c.not is xori with all ones
                      instr_o = {12'hfff, rsdc, 3'b100, rsdc, OPCODE_OPIMM};
                    end
                    default: begin
                      // c.zext.w is RV64 only, the rest unused
                      illegal_o = 1'b1;
                    end
                  endcase
                end else begin
                  illegal_o = 1'b1;
                end
              end
              default: begin
                // c.subw and c.addw are RV64 only
                illegal_o = 1'b1;
              end
            endcase
          end
        endcase
      end

      default: begin
        // c.beqz and c.bnez
        // bit 13 becomes funct3[0]
        instr_o = {{4{c[12]}}, c[6:5], c[2], 5'd0, rsdc, 2'b00, c[13], c[11:10], c[4:3],
                   c[12], OPCODE_BRANCH};
      end
    endcase

    // a disabled Zcb unary op keeps the and form
    if (illegal_o && (c[15:13] == 3'b100) && (c[11:10] == 2'b11)) begin
      instr_o = and_word;
    end
  end

endmodule

`default_nettype wire

// ==== src/cdec_quadrant2.sv ====
`include "cdec_settings.svh"

`timescale 1ns/1ps
`default_nettype none

module cdec_quadrant2 (
  input  cdec_pkg::cinstr_t cinstr_i,
  output cdec_pkg::instr_t  instr_o,
  output logic              illegal_o
);

  import cdec_pkg::*;

  logic [`CDEC_CLEN-1:0] c;
  // full register fields of quadrant 2
  logic [4:0] rd;
  logic [4:0] rs2;
  // c.lwsp expansion, also the word for the float slots
  instr_t lwsp_word;

  assign c   = cinstr_i;
  assign rd  = c[11:7];
  assign rs2 = c[6:2];

  // offset bits 7:6 | 5 | 4:2
  assign lwsp_word = {4'b0, c[3:2], c[12], c[6:4], 2'b00, REG_SP, 3'b010, rd, OPCODE_LOAD};

  always_comb begin
    instr_o   = lwsp_word;
    illegal_o = 1'b0;

    case (c[15:13])
      3'b000: begin
        // c.slli
        // rd or shamt of zero is a hint and expands as is
        instr_o = {7'b0, rs2, rd, 3'b001, rd, OPCODE_OPIMM};
        if (c[12]) begin
          illegal_o = 1'b1;
        end
      end

      3'b010: begin
        // c.lwsp
        // loading into x0 is reserved
        instr_o = lwsp_word;
        if (rd == 5'd0) begin
          illegal_o = 1'b1;
        end
      end

      ////////////////////////////////////////
      // jumps, moves and adds
      ////////////////////////////////////////
      3'b100: begin
        if (!c[12]) begin
          if (rs2 == 5'd0) begin
            // c.jr
            instr_o = {12'b0, rd, 3'b000, 5'd0, OPCODE_JALR};
            // rs1 of x0 is reserved
            if (rd == 5'd0) begin
              illegal_o = 1'b1;
            end
          end else begin
            // c.mv adds rs2 to x0
            instr_o = {7'b0, rs2, 5'd0, 3'b000, rd, OPCODE_OP};
          end
        end else begin
          if (rs2 == 5'd0) begin
            if (rd == 5'd0) begin
              instr_o = EBREAK_WORD;
            end else begin
              // c.jalr links to ra
              instr_o = {12'b0, rd, 3'b000, REG_RA, OPCODE_JALR};
            end
          end else begin
            // c.add
            instr_o = {7'b0, rs2, rd, 3'b000, rd, OPCODE_OP};
          end
        end
      end

      3'b110: begin
        // c.swsp with offset bits 7:6 | 5:2
        instr_o = {4'b0, c[8:7], c[12], rs2, REG_SP, 3'b010, c[11:9], 2'b00, OPCODE_STORE};
      end

      default: begin
        // float stack loads and stores
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/cdec_expand_stage.sv ====
`include "cdec_settings.svh"

`timescale 1ns/1ps
`default_nettype none

module cdec_expand_stage #(
  parameter bit ZC_EXT = `CDEC_ZC_EXT,
  parameter bit M_EXT  = `CDEC_M_EXT,
  parameter bit B_EXT  = `CDEC_B_EXT
) (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             valid_i,
  input  cdec_pkg::instr_t instr_i,
  output logic             valid_o,
  output cdec_pkg::instr_t instr_o,
  output logic             is_compressed_o,
  output logic             illegal_o
);

  import cdec_pkg::*;

  ////////////////////////////////////////
  // quadrant expanders
  ////////////////////////////////////////

  // lower halfword goes to all three in parallel
  cinstr_t   cinstr;
  quadrant_e quad;

  instr_t q0_instr;
  instr_t q1_instr;
  instr_t q2_instr;
  logic   q0_illegal;
  logic   q1_illegal;
  logic   q2_illegal;

  // selected result before the register
  instr_t sel_instr;
  logic   sel_compressed;
  logic   sel_illegal;

  assign cinstr = instr_i[`CDEC_CLEN-1:0];
  assign quad   = quadrant_e'(instr_i[1:0]);

  cdec_quadrant0 #(
    .ZC_EXT (ZC_EXT)
  ) u_q0 (
    .cinstr_i  (cinstr),
    .instr_o   (q0_instr),
    .illegal_o (q0_illegal)
  );

  cdec_quadrant1 #(
    .ZC_EXT (ZC_EXT),
    .M_EXT  (M_EXT),
    .B_EXT  (B_EXT)
  ) u_q1 (
    .cinstr_i  (cinstr),
    .instr_o   (q1_instr),
    .illegal_o (q1_illegal)
  );

  cdec_quadrant2 u_q2 (
    .cinstr_i  (cinstr),
    .instr_o   (q2_instr),
    .illegal_o (q2_illegal)
  );

  // pick by the low two bits
  always_comb begin
    sel_compressed = (quad != FULL);
    case (quad)
      Q0: begin
        sel_instr   = q0_instr;
        sel_illegal = q0_illegal;
      end
      Q1: begin
        sel_instr   = q1_instr;
        sel_illegal = q1_illegal;
      end
      Q2: begin
        sel_instr   = q2_instr;
        sel_illegal = q2_illegal;
      end
      default: begin
        // 32-bit word goes through untouched
        sel_instr   = instr_i;
        sel_illegal = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // pipeline register into decode
  ////////////////////////////////////////

  // data only loads on a valid word
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o         <= 1'b0;
      instr_o         <= '0;
      is_compressed_o <= 1'b0;
      illegal_o       <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        instr_o         <= sel_instr;
        is_compressed_o <= sel_compressed;
        illegal_o       <= sel_illegal;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic reset_o
);

  // free running clock, 8 ns period by default
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // reset held for a few rising edges, released away from the edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb/tb_cdec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cdec;

  localparam int CLK_PERIOD  = 8;
  // random, directed and burst words together, rounded up
  localparam int NUM_VECTORS = 260;

  logic        clk;
  logic        reset_i;
  logic        valid_i;
  logic [31:0] instr_i;
  logic        valid_o;
  logic [31:0] instr_o;
  logic        is_compressed_o;
  logic        illegal_o;

  int seed = 42951;
  int cycle = 0;

  // expected results, one entry per accepted word
  logic [31:0] exp_word[$];
  logic        exp_comp[$];
  logic        exp_ill[$];
  logic        exp_chk[$];
  int          exp_cyc[$];
  string       exp_name[$];

  tb_clk_gen #(
    .HALF_PERIOD  (CLK_PERIOD / 2),
    .RESET_CYCLES (4)
  ) u_clk_gen (
    .clk_o   (clk),
    .reset_o (reset_i)
  );

  cdec_expand_stage #(
    .ZC_EXT (1'b1),
    .M_EXT  (1'b1),
    .B_EXT  (1'b1)
  ) u_dut (
    .clk             (clk),
    .reset_i         (reset_i),
    .valid_i         (valid_i),
    .instr_i         (instr_i),
    .valid_o         (valid_o),
    .instr_o         (instr_o),
    .is_compressed_o (is_compressed_o),
    .illegal_o       (illegal_o)
  );

  ////////////////////////////////////////
  // failure reporting
  ////////////////////////////////////////

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("Fail %s expected %h actual %h", name, exp, act);
    $display("STATUS: FAIL");
    $fatal(1, "value mismatch");
  endtask

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // one word per falling edge, with its expected result queued
  task automatic send_word(input string name, input logic [31:0] word, input logic [31:0] exp,
                           input logic comp, input logic ill, input logic chk);
    @(negedge clk);
    valid_i = 1'b1;
    instr_i = word;
    exp_word.push_back(exp);
    exp_comp.push_back(comp);
    exp_ill.push_back(ill);
    exp_chk.push_back(chk);
    exp_cyc.push_back(cycle);
    exp_name.push_back(name);
  endtask

  // compressed halfword with a random upper half that must be ignored
  task automatic send_half(input string name, input logic [15:0] half, input logic [31:0] exp,
                           input logic ill);
    logic [31:0] r;
    r = $random(seed);
    send_word(name, {r[31:16], half}, exp, 1'b1, ill, ~ill);
  endtask

  task automatic send_full(input string name);
    logic [31:0] w;
    w = $random(seed);
    w[1:0] = 2'b11;
    send_word(name, w, w, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      valid_i = 1'b0;
      instr_i = '0;
    end
  endtask

  // count rising edges so latency can be measured
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////
  // output checks on the falling edge
  ////////////////////////////////////////

  always @(negedge clk) begin : check_outputs
    if (!reset_i) begin
      if (valid_o) begin
        assert (exp_word.size() > 0)
          else stop_run("valid_o was raised with no word pending");
        assert (exp_cyc[0] == cycle - 1)
          else stop_run("valid_o did not follow valid_i by exactly one cycle");
        assert (!exp_chk[0] || (instr_o == exp_word[0]))
          else fail_value(exp_name[0], exp_word[0], instr_o);
        assert (is_compressed_o == exp_comp[0])
          else fail_value({exp_name[0], " is_compressed"}, 32'(exp_comp[0]),
                          32'(is_compressed_o));
        assert (illegal_o == exp_ill[0])
          else fail_value({exp_name[0], " illegal"}, 32'(exp_ill[0]), 32'(illegal_o));
        void'(exp_word.pop_front());
        void'(exp_comp.pop_front());
        void'(exp_ill.pop_front());
        void'(exp_chk.pop_front());
        void'(exp_cyc.pop_front());
        void'(exp_name.pop_front());
      end else if (exp_word.size() > 0) begin
        // a word that is older than one cycle has been lost
        assert (exp_cyc[0] >= cycle - 1)
          else stop_run("valid_o missing for an accepted word");
      end
    end
  end

  // watchdog sized from the vector count
  initial begin
    #((NUM_VECTORS * 2 + 100) * CLK_PERIOD);
    $display("watchdog timeout, the run did not finish");
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    valid_i = 1'b0;
    instr_i = '0;

    // reset state
    @(negedge clk);
    while (reset_i) begin
      @(negedge clk);
    end
    assert (valid_o == 1'b0) else fail_value("reset valid_o", 32'd0, 32'(valid_o));
    assert (instr_o == 32'd0) else fail_value("reset instr_o", 32'd0, instr_o);
    assert (is_compressed_o == 1'b0)
      else fail_value("reset is_compressed", 32'd0, 32'(is_compressed_o));
    assert (illegal_o == 1'b0) else fail_value("reset illegal", 32'd0, 32'(illegal_o));

    // back to back burst, then idle cycles
    send_full("burst");
    send_half("burst c.nop", 16'h0001, 32'h00000013, 1'b0);
    send_full("burst");
    send_half("burst c.mv", 16'h852e, 32'h00b00533, 1'b0);
    send_full("burst");
    send_full("burst");
    idle(4);

    // passthrough of 32-bit words
    repeat (200) begin
      send_full("passthrough");
    end
    idle(2);

    // quadrant 0
    send_half("c.addi4spn", 16'h0040, 32'h00410413, 1'b0);
    send_half("c.lw", 16'h4044, 32'h00442483, 1'b0);
    send_half("c.sw", 16'hc044, 32'h00942223, 1'b0);
    // quadrant 1
    send_half("c.nop", 16'h0001, 32'h00000013, 1'b0);
    send_half("c.addi", 16'h157d, 32'hfff50513, 1'b0);
    send_half("c.jal", 16'h2009, 32'h002000ef, 1'b0);
    send_half("c.j", 16'hbffd, 32'hfffff06f, 1'b0);
    send_half("c.li", 16'h4595, 32'h00500593, 1'b0);
    send_half("c.lui", 16'h6605, 32'h00001637, 1'b0);
    send_half("c.addi16sp", 16'h6141, 32'h01010113, 1'b0);
    send_half("c.srli", 16'h800d, 32'h00345413, 1'b0);
    send_half("c.srai", 16'h840d, 32'h40345413, 1'b0);
    send_half("c.andi", 16'h987d, 32'hfff47413, 1'b0);
    send_half("c.sub", 16'h8c05, 32'h40940433, 1'b0);
    send_half("c.xor", 16'h8c25, 32'h00944433, 1'b0);
    send_half("c.or", 16'h8c45, 32'h00946433, 1'b0);
    send_half("c.and", 16'h8c65, 32'h00947433, 1'b0);
    send_half("c.beqz", 16'hc009, 32'h00040163, 1'b0);
    send_half("c.bnez", 16'he009, 32'h00041163, 1'b0);
    // quadrant 2
    send_half("c.slli", 16'h050e, 32'h00351513, 1'b0);
    send_half("c.lwsp", 16'h4512, 32'h00412503, 1'b0);
    send_half("c.jr", 16'h8502, 32'h00050067, 1'b0);
    send_half("c.mv", 16'h852e, 32'h00b00533, 1'b0);
    send_half("c.ebreak", 16'h9002, 32'h00100073, 1'b0);
    send_half("c.jalr", 16'h9502, 32'h000500e7, 1'b0);
    send_half("c.add", 16'h952e, 32'h00b50533, 1'b0);
    send_half("c.swsp", 16'hc22e, 32'h00b12223, 1'b0);

    // Zcb forms
    send_half("c.lbu", 16'h8044, 32'h00144483, 1'b0);
    send_half("c.lhu", 16'h8424, 32'h00245483, 1'b0);
    send_half("c.lh", 16'h8464, 32'h00241483, 1'b0);
    send_half("c.sb", 16'h8844, 32'h009400a3, 1'b0);
    send_half("c.sh", 16'h8c24, 32'h00941123, 1'b0);
    send_half("c.mul", 16'h9c45, 32'h02940433, 1'b0);
    send_half("c.zext.b", 16'h9c61, 32'h0ff47413, 1'b0);
    send_half("c.sext.b", 16'h9c65, 32'h60441413, 1'b0);
    send_half("c.zext.h", 16'h9c69, 32'h08044433, 1'b0);
    send_half("c.sext.h", 16'h9c6d, 32'h60541413, 1'b0);
    send_half("c.not", 16'h9c75, 32'hfff44413, 1'b0);

    // illegal encodings, only the flags are checked
    send_half("all zero", 16'h0000, 32'h0, 1'b1);
    send_half("c.lwsp x0", 16'h4002, 32'h0, 1'b1);
    send_half("c.jr x0", 16'h8002, 32'h0, 1'b1);
    send_half("c.flw", 16'h6000, 32'h0, 1'b1);
    send_half("c.fsw", 16'he000, 32'h0, 1'b1);
    send_half("c.fswsp", 16'he002, 32'h0, 1'b1);
    send_half("c.subw", 16'h9c01, 32'h0, 1'b1);
    send_half("c.sh bit6", 16'h8c44, 32'h0, 1'b1);
    send_half("zcb unary 4", 16'h9c71, 32'h0, 1'b1);
    send_half("zcb unary 6", 16'h9c79, 32'h0, 1'b1);
    send_half("zcb unary 7", 16'h9c7d, 32'h0, 1'b1);
    idle(1);

    // drain, the watchdog covers a stuck queue
    while (exp_word.size() > 0) begin
      @(negedge clk);
    end
    idle(3);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/cdec_pkg.sv
src/cdec_quadrant0.sv
src/cdec_quadrant1.sv
src/cdec_quadrant2.sv
src/cdec_expand_stage.sv
tb/tb_clk_gen.sv
tb/tb_cdec.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
# the exit status is that of the simulation

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f tb.f --top-module tb_cdec -o sim_cdec &&
  ./obj_dir/sim_cdec ||
  exit 1
